// ==== flist.f ====
hw/soc_pkg.sv
hw/iomem_if.sv
hw/iomem_decoder.sv
hw/wait_state_ram.sv
hw/uart_tx_periph.sv
hw/pwm_periph.sv
hw/periph_subsystem.sv
bench/tb_periph_subsystem.sv

// ==== bench/tb_periph_subsystem.sv ====
`timescale 1ns/1ps

module tb_periph_subsystem;

  typedef enum int {BUS_WRITE, BUS_READ, UART_FRAME, PWM_WINDOW} step_kind_e;

  typedef struct {
    step_kind_e  kind;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] expected;
  } step_t;

  localparam int READY_TIMEOUT = 20;
  localparam int UART_DIV      = 12;
  localparam int PWM_PERIOD    = 10;

  logic        clk;
  logic        resetn;
  logic        iomem_valid;
  logic [3:0]  iomem_wstrb;
  logic [31:0] iomem_addr;
  logic [31:0] iomem_wdata;
  logic        iomem_ready;
  logic [31:0] iomem_rdata;
  logic        uart_tx;
  logic        pwm0;
  logic        pwm1;

  step_t       steps [$];
  logic [31:0] shadow_ram [soc_pkg::RAM_WORDS];
  logic [31:0] pwm_regs [4]; // period0, duty0, period1, duty1 as written over the bus.
  int unsigned lcg_state = 99825;
  int          checks    = 0;
  int          errors    = 0;
  int          timeouts  = 0;
  time         fall_time;
  logic        fall_seen = 1'b0;

  periph_subsystem periph_subsystem_i (
    .clk           ( clk ),
    .resetn        ( resetn ),
    .iomem_valid_i ( iomem_valid ),
    .iomem_wstrb_i ( iomem_wstrb ),
    .iomem_addr_i  ( iomem_addr ),
    .iomem_wdata_i ( iomem_wdata ),
    .iomem_ready_o ( iomem_ready ),
    .iomem_rdata_o ( iomem_rdata ),
    .uart_tx_o     ( uart_tx ),
    .pwm0_o        ( pwm0 ),
    .pwm1_o        ( pwm1 )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // the first falling edge after the TXDATA write is the start bit.
  always @(negedge uart_tx) begin
    if (!fall_seen) begin
      fall_time = $time;
      fall_seen = 1'b1;
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] word;
    word = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) word[8*b +: 8] = new_word[8*b +: 8];
    end
    return word;
  endfunction

  function automatic logic in_ram(input logic [31:0] addr);
    return addr >= soc_pkg::RAM_BASE && addr < soc_pkg::RAM_BASE + 32'(soc_pkg::RAM_WORDS * 4);
  endfunction

  function automatic logic in_pwm(input logic [31:0] addr);
    return addr >= soc_pkg::PWM_BASE && addr < soc_pkg::PWM_BASE + 32'h10;
  endfunction

  task automatic add_step(input step_kind_e kind, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] wstrb,
                          input logic [31:0] expected);
    step_t s;
    s.kind     = kind;
    s.addr     = addr;
    s.wdata    = wdata;
    s.wstrb    = wstrb;
    s.expected = expected;
    steps.push_back(s);
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // called at a falling edge, and returns at one with valid low again.
  task automatic bus_transfer(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, output logic [31:0] rdata,
                              output int edges);
    edges       = 0;
    rdata       = '0;
    iomem_valid = 1'b1;
    iomem_addr  = addr;
    iomem_wdata = wdata;
    iomem_wstrb = wstrb;
    do begin
      @(negedge clk);
      edges++;
    end while (!iomem_ready && edges < READY_TIMEOUT);
    if (iomem_ready) begin
      rdata = iomem_rdata;
    end else begin
      $display("timeout: address %h gave no ready within %0d cycles", addr, READY_TIMEOUT);
      timeouts++;
    end
    @(negedge clk); // the transfer completes at the rising edge in between.
    iomem_valid = 1'b0;
    iomem_wstrb = '0;
  endtask

  task automatic record_write(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb);
    int idx;
    if (in_ram(addr)) begin
      idx = int'((addr - soc_pkg::RAM_BASE) >> 2);
      shadow_ram[idx] = merge_bytes(shadow_ram[idx], wdata, wstrb);
    end else if (in_pwm(addr)) begin
      idx = int'((addr - soc_pkg::PWM_BASE) >> 2);
      pwm_regs[idx] = merge_bytes(pwm_regs[idx], wdata, wstrb);
    end
  endtask

  task automatic decode_uart_frame(input logic [7:0] data);
    logic [31:0] rdata;
    int          edges;
    int          waited;
    int          bit_cycle;
    logic        expected_bit;
    fall_seen = 1'b0;
    bus_transfer(soc_pkg::UART_BASE + 32'(soc_pkg::UART_TXDATA_OFS), {24'h0, data}, 4'b0001,
                 rdata, edges);
    bus_transfer(soc_pkg::UART_BASE + 32'(soc_pkg::UART_STATUS_OFS), '0, '0, rdata, edges);
    compare_value("iomem_rdata_o (uart status busy)", 32'd1, rdata);
    waited = 0;
    while (!fall_seen && waited < READY_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!fall_seen) begin
      $display("timeout: uart_tx_o showed no start bit after the TXDATA write");
      timeouts++;
    end else begin
      for (int k = 0; k < 10; k++) begin
        bit_cycle = k * UART_DIV + UART_DIV / 2; // middle of bit k, counted from the start edge.
        waited    = 0;
        while (int'(($time - fall_time + 10) / 20) < bit_cycle && waited < 2 * UART_DIV) begin
          @(negedge clk);
          waited++;
        end
        if (int'(($time - fall_time + 10) / 20) < bit_cycle) begin
          $display("timeout: middle of uart bit %0d was never reached", k);
          timeouts++;
        end
        if (k == 0) expected_bit = 1'b0;
        else if (k == 9) expected_bit = 1'b1;
        else expected_bit = data[k-1];
        compare_value($sformatf("uart_tx_o (bit %0d)", k), 32'(expected_bit), 32'(uart_tx));
      end
    end
    waited = 0;
    do begin
      bus_transfer(soc_pkg::UART_BASE + 32'(soc_pkg::UART_STATUS_OFS), '0, '0, rdata, edges);
      waited++;
    end while (rdata[0] && waited < 40);
    compare_value("iomem_rdata_o (uart status idle)", 32'd0, rdata);
  endtask

  task automatic count_pwm_high(input int periods);
    int          window;
    int          high0;
    int          high1;
    logic [31:0] on0;
    logic [31:0] on1;
    window = periods * int'(pwm_regs[0]);
    high0  = 0;
    high1  = 0;
    on0    = (pwm_regs[1] < pwm_regs[0]) ? pwm_regs[1] : pwm_regs[0];
    on1    = (pwm_regs[3] < pwm_regs[2]) ? pwm_regs[3] : pwm_regs[2];
    for (int c = 0; c < window; c++) begin
      @(negedge clk);
      if (pwm0) high0++;
      if (pwm1) high1++;
    end
    compare_value("pwm0_o high cycles", 32'(periods) * on0, 32'(high0));
    compare_value("pwm1_o high cycles", 32'(periods) * on1, 32'(high1));
  endtask

  task automatic build_table();
    int          ram_word [4];
    logic [3:0]  part_strb [4];
    logic [31:0] addr;
    ram_word  = '{0, 1, 511, soc_pkg::RAM_WORDS - 1};
    part_strb = '{4'b0001, 4'b0110, 4'b1100, 4'b1010};
    foreach (ram_word[i]) begin
      addr = soc_pkg::RAM_BASE + 32'(ram_word[i] * 4);
      add_step(BUS_WRITE, addr, next_random(), 4'b1111, '0);
    end
    foreach (ram_word[i]) begin
      addr = soc_pkg::RAM_BASE + 32'(ram_word[i] * 4);
      add_step(BUS_WRITE, addr, next_random(), part_strb[i], '0);
      add_step(BUS_READ, addr, '0, '0, '0);
    end
    foreach (ram_word[i]) begin
      add_step(BUS_READ, soc_pkg::RAM_BASE + 32'(ram_word[i] * 4), '0, '0, '0);
    end
    add_step(BUS_READ, 32'h1000_0000, '0, '0, soc_pkg::UNMAPPED_RDATA);
    add_step(BUS_WRITE, soc_pkg::UART_BASE + soc_pkg::PERIPH_SPAN, 32'h1234_5678, 4'hF, '0);
    add_step(BUS_READ, soc_pkg::UART_BASE + soc_pkg::PERIPH_SPAN, '0, '0,
             soc_pkg::UNMAPPED_RDATA);
    add_step(BUS_READ, soc_pkg::RAM_BASE + 32'(soc_pkg::RAM_WORDS * 4), '0, '0,
             soc_pkg::UNMAPPED_RDATA);
    addr = soc_pkg::UART_BASE;
    add_step(BUS_READ, addr + 32'(soc_pkg::UART_STATUS_OFS), '0, '0, 32'd0);
    add_step(BUS_READ, addr + 32'(soc_pkg::UART_DIV_OFS), '0, '0, 32'(soc_pkg::UART_DIV_RESET));
    add_step(BUS_WRITE, addr + 32'(soc_pkg::UART_DIV_OFS), 32'(UART_DIV), 4'hF, '0);
    add_step(BUS_READ, addr + 32'(soc_pkg::UART_DIV_OFS), '0, '0, 32'(UART_DIV));
    add_step(UART_FRAME, addr, 32'h0000_00A5, '0, '0);
    add_step(UART_FRAME, addr, 32'h0000_003C, '0, '0);
    addr = soc_pkg::PWM_BASE;
    add_step(BUS_READ, addr + 32'(soc_pkg::PWM_PERIOD0_OFS), '0, '0, 32'd0);
    add_step(BUS_WRITE, addr + 32'(soc_pkg::PWM_PERIOD0_OFS), 32'(PWM_PERIOD), 4'hF, '0);
    add_step(BUS_WRITE, addr + 32'(soc_pkg::PWM_DUTY0_OFS), 32'd3, 4'hF, '0);
    add_step(BUS_WRITE, addr + 32'(soc_pkg::PWM_PERIOD1_OFS), 32'(PWM_PERIOD), 4'hF, '0);
    add_step(BUS_WRITE, addr + 32'(soc_pkg::PWM_DUTY1_OFS), 32'd15, 4'hF, '0); // above period.
    add_step(BUS_READ, addr + 32'(soc_pkg::PWM_PERIOD0_OFS), '0, '0, 32'(PWM_PERIOD));
    add_step(BUS_READ, addr + 32'(soc_pkg::PWM_DUTY0_OFS), '0, '0, 32'd3);
    add_step(BUS_READ, addr + 32'(soc_pkg::PWM_PERIOD1_OFS), '0, '0, 32'(PWM_PERIOD));
    add_step(BUS_READ, addr + 32'(soc_pkg::PWM_DUTY1_OFS), '0, '0, 32'd15);
    add_step(PWM_WINDOW, addr, 32'd8, '0, '0);
  endtask

  initial begin
    logic [31:0] rdata;
    int          edges;
    resetn      = 1'b0;
    iomem_valid = 1'b0;
    iomem_wstrb = '0;
    iomem_addr  = '0;
    iomem_wdata = '0;
    pwm_regs    = '{default: '0};
    build_table();
    repeat (2) @(negedge clk);
    resetn = 1'b1;
    compare_value("iomem_ready_o", 32'd0, 32'(iomem_ready));
    compare_value("uart_tx_o", 32'd1, 32'(uart_tx));
    compare_value("pwm0_o", 32'd0, 32'(pwm0));
    compare_value("pwm1_o", 32'd0, 32'(pwm1));
    foreach (steps[i]) begin
      case (steps[i].kind)
        BUS_WRITE, BUS_READ: begin
          bus_transfer(steps[i].addr, steps[i].wdata, steps[i].wstrb, rdata, edges);
          compare_value("iomem_ready_o latency",
                        in_ram(steps[i].addr) ? soc_pkg::RAM_WAIT_CYCLES : 1, edges);
          if (steps[i].kind == BUS_WRITE) begin
            record_write(steps[i].addr, steps[i].wdata, steps[i].wstrb);
          end else if (in_ram(steps[i].addr)) begin
            compare_value("iomem_rdata_o",
                          shadow_ram[(steps[i].addr - soc_pkg::RAM_BASE) >> 2], rdata);
          end else begin
            compare_value("iomem_rdata_o", steps[i].expected, rdata);
          end
        end
        UART_FRAME: decode_uart_frame(steps[i].wdata[7:0]);
        PWM_WINDOW: count_pwm_high(int'(steps[i].wdata));
        default: ;
      endcase
    end
    $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== hw/periph_subsystem.sv ====
`timescale 1ns/1ps

module periph_subsystem (
  input  logic        clk,
  input  logic        resetn,
  input  logic        iomem_valid_i,
  input  logic [3:0]  iomem_wstrb_i,
  input  logic [31:0] iomem_addr_i,
  input  logic [31:0] iomem_wdata_i,
  output logic        iomem_ready_o,
  output logic [31:0] iomem_rdata_o,
  output logic        uart_tx_o,
  output logic        pwm0_o,
  output logic        pwm1_o
);

  iomem_if host_bus ();
  iomem_if ram_bus ();
  iomem_if uart_bus ();
  iomem_if pwm_bus ();

  logic [1:0] pwm_w;

  assign host_bus.valid = iomem_valid_i;
  assign host_bus.wstrb = iomem_wstrb_i;
  assign host_bus.addr  = iomem_addr_i;
  assign host_bus.wdata = iomem_wdata_i;
  assign iomem_ready_o  = host_bus.ready;
  assign iomem_rdata_o  = host_bus.rdata;

  iomem_decoder decoder_i (
    .clk    ( clk ),
    .resetn ( resetn ),
    .m_i    ( host_bus.target ),
    .ram_o  ( ram_bus.master ),
    .uart_o ( uart_bus.master ),
    .pwm_o  ( pwm_bus.master )
  );

  wait_state_ram ram_i (
    .clk    ( clk ),
    .resetn ( resetn ),
    .bus_i  ( ram_bus.target )
  );

  uart_tx_periph uart_i (
    .clk    ( clk ),
    .resetn ( resetn ),
    .bus_i  ( uart_bus.target ),
    .tx_o   ( uart_tx_o )
  );

  pwm_periph pwm_i (
    .clk    ( clk ),
    .resetn ( resetn ),
    .bus_i  ( pwm_bus.target ),
    .pwm_o  ( pwm_w )
  );

  assign pwm0_o = pwm_w[0];
  assign pwm1_o = pwm_w[1];

endmodule

// ==== hw/pwm_periph.sv ====
`timescale 1ns/1ps

module pwm_periph (
  input  logic       clk,
  input  logic       resetn,
  iomem_if.target    bus_i,
  output logic [1:0] pwm_o
);

  logic [31:0] period_q [2];
  logic [31:0] duty_q [2];
  logic [31:0] cnt_q [2];
  logic        ready_q;
  logic [31:0] rdata_q;
  logic [31:0] reg_rdata;
  logic        req;
  logic        wr;

  assign req = bus_i.valid && !ready_q;
  assign wr  = req && |bus_i.wstrb;

  always_comb begin
    case (bus_i.addr[7:0])
      soc_pkg::PWM_PERIOD0_OFS: reg_rdata = period_q[0];
      soc_pkg::PWM_DUTY0_OFS:   reg_rdata = duty_q[0];
      soc_pkg::PWM_PERIOD1_OFS: reg_rdata = period_q[1];
      soc_pkg::PWM_DUTY1_OFS:   reg_rdata = duty_q[1];
      default:                  reg_rdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
      for (int ch = 0; ch < 2; ch++) begin
        period_q[ch] <= '0; // a zero period keeps the pin low.
        duty_q[ch]   <= '0;
      end
    end else begin
      ready_q <= req;
      if (wr) begin
        case (bus_i.addr[7:0])
          soc_pkg::PWM_PERIOD0_OFS:
            period_q[0] <= soc_pkg::apply_wstrb(period_q[0], bus_i.wdata, bus_i.wstrb);
          soc_pkg::PWM_DUTY0_OFS:
            duty_q[0] <= soc_pkg::apply_wstrb(duty_q[0], bus_i.wdata, bus_i.wstrb);
          soc_pkg::PWM_PERIOD1_OFS:
            period_q[1] <= soc_pkg::apply_wstrb(period_q[1], bus_i.wdata, bus_i.wstrb);
          soc_pkg::PWM_DUTY1_OFS:
            duty_q[1] <= soc_pkg::apply_wstrb(duty_q[1], bus_i.wdata, bus_i.wstrb);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      rdata_q <= reg_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int ch = 0; ch < 2; ch++) begin
        cnt_q[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < 2; ch++) begin
        // a shortened period also wraps a counter that is already past it.
        if (period_q[ch] == '0 || cnt_q[ch] >= period_q[ch] - 32'd1) begin
          cnt_q[ch] <= '0;
        end else begin
          cnt_q[ch] <= cnt_q[ch] + 32'd1;
        end
      end
    end
  end

  for (genvar ch = 0; ch < 2; ch++) begin : g_out
    assign pwm_o[ch] = (period_q[ch] != '0) && (cnt_q[ch] < duty_q[ch]);
  end

  assign bus_i.ready = ready_q;
  assign bus_i.rdata = rdata_q;

endmodule

// ==== hw/uart_tx_periph.sv ====
`timescale 1ns/1ps

module uart_tx_periph (
  input  logic    clk,
  input  logic    resetn,
  iomem_if.target bus_i,
  output logic    tx_o
);

  logic        ready_q;
  logic [31:0] rdata_q;
  logic [31:0] reg_rdata;
  logic [15:0] div_q;
  logic [31:0] div_word;
  logic        busy_q;
  logic [3:0]  bit_cnt_q;
  logic [15:0] div_cnt_q;
  logic [7:0]  shift_q;
  logic        tx_q;
  logic        req;
  logic        start_frame;
  logic        bit_done;

  assign req         = bus_i.valid && !ready_q;
  assign start_frame = req && bus_i.wstrb[0] && !busy_q
                       && (bus_i.addr[7:0] == soc_pkg::UART_TXDATA_OFS);
  assign bit_done    = busy_q && (div_cnt_q + 16'd1 >= div_q); // a zero divider acts as one.
  assign div_word    = soc_pkg::apply_wstrb({16'h0000, div_q}, bus_i.wdata, bus_i.wstrb);

  always_comb begin
    case (bus_i.addr[7:0])
      soc_pkg::UART_STATUS_OFS: reg_rdata = {31'b0, busy_q};
      soc_pkg::UART_DIV_OFS:    reg_rdata = {16'h0000, div_q};
      default:                  reg_rdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q   <= 1'b0;
      div_q     <= soc_pkg::UART_DIV_RESET;
      busy_q    <= 1'b0;
      bit_cnt_q <= '0;
      div_cnt_q <= '0;
      tx_q      <= 1'b1;
    end else begin
      ready_q <= req;
      if (req && |bus_i.wstrb && bus_i.addr[7:0] == soc_pkg::UART_DIV_OFS) begin
        div_q <= div_word[15:0];
      end
      if (start_frame) begin
        busy_q    <= 1'b1;
        bit_cnt_q <= '0;
        div_cnt_q <= '0;
        tx_q      <= 1'b0; // start bit.
      end else if (bit_done) begin
        div_cnt_q <= '0;
        bit_cnt_q <= bit_cnt_q + 4'd1;
        if (bit_cnt_q == 4'd9) begin
          busy_q <= 1'b0; // end of the stop bit.
        end else if (bit_cnt_q == 4'd8) begin
          tx_q <= 1'b1;
        end else begin
          tx_q <= shift_q[0];
        end
      end else if (busy_q) begin
        div_cnt_q <= div_cnt_q + 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      rdata_q <= reg_rdata;
    end
    if (start_frame) begin
      shift_q <= bus_i.wdata[7:0];
    end else if (bit_done && bit_cnt_q < 4'd8) begin
      shift_q <= shift_q >> 1; // data goes out LSB first.
    end
  end

  assign bus_i.ready = ready_q;
  assign bus_i.rdata = rdata_q;
  assign tx_o        = tx_q;

  a_idle_line_high: assert property (
    @(posedge clk) disable iff (!resetn)
    !busy_q |-> tx_o
  );

endmodule

// ==== hw/wait_state_ram.sv ====
`timescale 1ns/1ps

module wait_state_ram (
  input logic     clk,
  input logic     resetn,
  iomem_if.target bus_i
);

  logic [31:0]                        mem_q [soc_pkg::RAM_WORDS];
  logic [soc_pkg::RAM_WAIT_BITS-1:0]  wait_q;
  logic                               ready_q;
  logic [31:0]                        rdata_q;
  logic [soc_pkg::RAM_ADDR_BITS-1:0]  word_idx;
  logic                               last_wait;

  assign word_idx  = bus_i.addr[soc_pkg::RAM_ADDR_BITS+1:2]; // region base is size aligned.
  assign last_wait = (int'(wait_q) == soc_pkg::RAM_WAIT_CYCLES - 1);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      wait_q  <= '0;
      ready_q <= 1'b0;
    end else if (ready_q) begin
      ready_q <= 1'b0; // the transfer completes at this edge.
    end else if (bus_i.valid) begin
      if (last_wait) begin
        ready_q <= 1'b1;
        wait_q  <= '0;
      end else begin
        wait_q <= wait_q + 1'b1;
      end
    end else begin
      wait_q <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (bus_i.valid && !ready_q && last_wait) begin
      rdata_q <= mem_q[word_idx];
    end
    if (bus_i.valid && ready_q && |bus_i.wstrb) begin
      mem_q[word_idx] <= soc_pkg::apply_wstrb(mem_q[word_idx], bus_i.wdata, bus_i.wstrb);
    end
  end

  assign bus_i.ready = ready_q;
  assign bus_i.rdata = rdata_q;

  // the master must hold its request while the RAM counts down.
  a_req_stable: assert property (
    @(posedge clk) disable iff (!resetn)
    bus_i.valid && !bus_i.ready |=>
      bus_i.valid && $stable(bus_i.addr) && $stable(bus_i.wdata) && $stable(bus_i.wstrb)
  );

  a_ready_needs_valid: assert property (
    @(posedge clk) disable iff (!resetn)
    bus_i.ready |-> bus_i.valid
  );

endmodule

// ==== hw/iomem_decoder.sv ====
`timescale 1ns/1ps

module iomem_decoder (
  input logic     clk,
  input logic     resetn,
  iomem_if.target m_i,
  iomem_if.master ram_o,
  iomem_if.master uart_o,
  iomem_if.master pwm_o
);

  logic ram_sel;
  logic uart_sel;
  logic pwm_sel;
  logic none_sel;
  logic unmapped_ready_q;

  assign ram_sel  = soc_pkg::in_region(m_i.addr, soc_pkg::RAM_BASE, soc_pkg::RAM_SPAN);
  assign uart_sel = soc_pkg::in_region(m_i.addr, soc_pkg::UART_BASE, soc_pkg::PERIPH_SPAN);
  assign pwm_sel  = soc_pkg::in_region(m_i.addr, soc_pkg::PWM_BASE, soc_pkg::PERIPH_SPAN);
  assign none_sel = !(ram_sel || uart_sel || pwm_sel);

  assign ram_o.valid  = m_i.valid && ram_sel;
  assign ram_o.wstrb  = m_i.wstrb;
  assign ram_o.addr   = m_i.addr;
  assign ram_o.wdata  = m_i.wdata;

  assign uart_o.valid = m_i.valid && uart_sel;
  assign uart_o.wstrb = m_i.wstrb;
  assign uart_o.addr  = m_i.addr;
  assign uart_o.wdata = m_i.wdata;

  assign pwm_o.valid  = m_i.valid && pwm_sel;
  assign pwm_o.wstrb  = m_i.wstrb;
  assign pwm_o.addr   = m_i.addr;
  assign pwm_o.wdata  = m_i.wdata;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      unmapped_ready_q <= 1'b0;
    end else begin
      unmapped_ready_q <= m_i.valid && none_sel && !unmapped_ready_q; // one-cycle answer.
    end
  end

  always_comb begin
    m_i.ready = unmapped_ready_q;
    m_i.rdata = soc_pkg::UNMAPPED_RDATA;
    if (ram_sel) begin
      m_i.ready = ram_o.ready;
      m_i.rdata = ram_o.rdata;
    end else if (uart_sel) begin
      m_i.ready = uart_o.ready;
      m_i.rdata = uart_o.rdata;
    end else if (pwm_sel) begin
      m_i.ready = pwm_o.ready;
      m_i.rdata = pwm_o.rdata;
    end
  end

  a_one_target_valid: assert property (
    @(posedge clk) disable iff (!resetn)
    $onehot0({ram_o.valid, uart_o.valid, pwm_o.valid})
  );

endmodule

// ==== hw/iomem_if.sv ====
`timescale 1ns/1ps

interface iomem_if;
  logic        valid;
  logic        ready;
  logic [3:0]  wstrb;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [31:0] rdata;

  modport master (
    output valid,
    output wstrb,
    output addr,
    output wdata,
    input  ready,
    input  rdata
  );

  modport target (
    input  valid,
    input  wstrb,
    input  addr,
    input  wdata,
    output ready,
    output rdata
  );
endinterface

// ==== hw/soc_pkg.sv ====
package soc_pkg;

  localparam logic [31:0] RAM_BASE        = 32'h4000_0000;
  localparam int          RAM_WORDS       = 1024;
  localparam int          RAM_ADDR_BITS   = $clog2(RAM_WORDS);
  localparam logic [31:0] RAM_SPAN        = 32'(RAM_WORDS * 4);
  localparam int          RAM_WAIT_CYCLES = 4;
  localparam int          RAM_WAIT_BITS   = $clog2(RAM_WAIT_CYCLES + 1);

  localparam logic [31:0] UART_BASE   = 32'h2000_0000;
  localparam logic [31:0] PWM_BASE    = 32'h2000_1000;
  localparam logic [31:0] PERIPH_SPAN = 32'h0000_0100;

  localparam logic [7:0]  UART_TXDATA_OFS = 8'h00;
  localparam logic [7:0]  UART_STATUS_OFS = 8'h04;
  localparam logic [7:0]  UART_DIV_OFS    = 8'h08;
  localparam logic [15:0] UART_DIV_RESET  = 16'd16;

  localparam logic [7:0]  PWM_PERIOD0_OFS = 8'h00;
  localparam logic [7:0]  PWM_DUTY0_OFS   = 8'h04;
  localparam logic [7:0]  PWM_PERIOD1_OFS = 8'h08;
  localparam logic [7:0]  PWM_DUTY1_OFS   = 8'h0C;

  localparam logic [31:0] UNMAPPED_RDATA = 32'hBAD0_BAD0;

  // merges the strobed bytes of a bus write into an existing word.
  function automatic logic [31:0] apply_wstrb(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  wstrb);
    logic [31:0] word;
    word = old_word;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        word[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return word;
  endfunction

  function automatic logic in_region(input logic [31:0] addr,
                                     input logic [31:0] base,
                                     input logic [31:0] span);
    return (addr - base) < span; // wraps below base, so one compare covers both bounds.
  endfunction

endpackage
